//--- rtl/pcPkg.sv
// host pipe bridge shared widths, routing codes, FIFO sizing and word types
package pcPkg;

  ////////////////////////////////////////////////////////////////////////////
  // word layout
  ////////////////////////////////////////////////////////////////////////////

  // code sits in the top byte, payload below it
  localparam int codeWidth    = 8;
  localparam int payloadWidth = 24;
  localparam int wordWidth    = codeWidth + payloadWidth;

  ////////////////////////////////////////////////////////////////////////////
  // pipe-in FIFO sizing
  ////////////////////////////////////////////////////////////////////////////

  // 512 words deep
  localparam int fifoAddrWidth = 9;
  localparam int fifoDepth     = 1 << fifoAddrWidth;
  // host block of 128 words
  localparam int blockWidth    = 7;

  ////////////////////////////////////////////////////////////////////////////
  // routing codes
  ////////////////////////////////////////////////////////////////////////////

  // filler upstream, discarded downstream
  localparam logic [codeWidth-1:0] nopCode    = 8'd64;
  // downstream words with this code go to the block emulator
  localparam logic [codeWidth-1:0] pcToBdCode = '1;
  // tag on block emulator results going upstream
  localparam logic [codeWidth-1:0] bdToPcCode = '1;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [codeWidth-1:0]     pcCode;
  typedef logic [payloadWidth-1:0]  pcPayload;
  typedef logic [wordWidth-1:0]     pcWord;
  // one extra bit so a full FIFO is distinct from an empty one
  typedef logic [fifoAddrWidth:0]   fifoCount;

endpackage

//--- rtl/pcChannel.sv
// valid/ack word channel carrying a routing code and a payload
`timescale 1ns/1ns

interface pcChannel import pcPkg::*; ();

  // word offered by the source
  logic     valid;
  // routing code, top byte of the pipe word
  pcCode    code;
  // data field, low 24 bits of the pipe word
  pcPayload payload;
  // sink takes the word this cycle
  logic     ack;

  // transfer happens on each rising edge with valid and ack both high
  // code and payload hold steady while valid waits for ack
  modport source (
    output valid,
    output code,
    output payload,
    input  ack
  );

  // ack may look at valid and at the sink's own state
  modport sink (
    input  valid,
    input  code,
    input  payload,
    output ack
  );

endinterface

//--- rtl/pipeInFifo.sv
// first-word-fall-through FIFO that sinks pipe-in words onto the downstream channel
`timescale 1ns/1ns

module pipeInFifo import pcPkg::*; (
  input  logic     okClk,
  input  logic     arstN,
  input  logic     wrEn,
  input  pcWord    wrData,
  output logic     ready,
  output fifoCount usedCount,
  pcChannel.source down
);

  ////////////////////////////////////////////////////////////////////////////
  // storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  pcWord mem [fifoDepth];

  // pointers wrap on their own at the depth
  logic [fifoAddrWidth-1:0] wrPtr;
  logic [fifoAddrWidth-1:0] rdPtr;

  logic  full;
  logic  wrAccept;
  logic  rdAccept;
  pcWord head;

  // top count bit only set at exactly 512 words
  assign full     = usedCount[fifoAddrWidth];
  // host writes into a full FIFO are dropped
  assign wrAccept = wrEn & ~full;
  // word leaves when the harness acks the head
  assign rdAccept = down.valid & down.ack;

  // write port
  always_ff @(posedge okClk) begin
    if (wrAccept) begin
      mem[wrPtr] <= wrData;
    end
  end

  // pointers and occupancy
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      usedCount <= '0;
    end else begin
      if (wrAccept) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (rdAccept) begin
        rdPtr <= rdPtr + 1'b1;
      end
      // simultaneous write and read leave the count alone
      usedCount <= usedCount + fifoCount'(wrAccept) - fifoCount'(rdAccept);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fall-through head onto the channel
  ////////////////////////////////////////////////////////////////////////////

  // head word visible the cycle after it is written
  assign head         = mem[rdPtr];
  assign down.valid   = (usedCount != '0);
  assign down.code    = head[wordWidth-1 -: codeWidth];
  assign down.payload = head[payloadWidth-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // host ready
  ////////////////////////////////////////////////////////////////////////////

  // upper count bits not all one means fewer than 384 used
  // so a whole 128-word block still fits
  assign ready = ~full & ~(&usedCount[fifoAddrWidth-1:blockWidth]);

endmodule

//--- rtl/upstreamMux.sv
// pipe-out source selecting the upstream channel word or a NOP filler
`timescale 1ns/1ns

module upstreamMux import pcPkg::*; (
  input  logic   pipeOutRead,
  output pcWord  pipeOutData,
  pcChannel.sink up
);

  // filler sent when nothing is pending
  pcWord nopWord;

  assign nopWord = {nopCode, pcPayload'(0)};

  // host reads are served in the same cycle
  always_comb begin
    if (pipeOutRead) begin
      if (up.valid) begin
        // pending word goes out and is consumed
        pipeOutData = {up.code, up.payload};
        up.ack      = 1'b1;
      end else begin
        // empty channel, answer with the NOP word
        pipeOutData = nopWord;
        up.ack      = 1'b0;
      end
    end else begin
      // no read, nothing taken
      pipeOutData = '0;
      up.ack      = 1'b0;
    end
  end

endmodule

//--- rtl/bdEmulator.sv
// block emulator returning the running payload sum for each accepted word
`timescale 1ns/1ns

module bdEmulator import pcPkg::*; (
  input  logic     okClk,
  input  logic     arstN,
  input  logic     inValid,
  input  pcPayload inPayload,
  output logic     inAck,
  output logic     outValid,
  output pcPayload outPayload,
  input  logic     outTaken
);

  ////////////////////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////////////////////

  logic     accept;
  pcPayload runSum;

  // room when the result register is empty or drains this cycle
  assign inAck  = ~outValid | outTaken;
  assign accept = inValid & inAck;

  ////////////////////////////////////////////////////////////////////////////
  // running sum and result register
  ////////////////////////////////////////////////////////////////////////////

  // sum only moves on accept, so it always equals the pending result
  // 24-bit add wraps around
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      runSum   <= '0;
      outValid <= 1'b0;
    end else begin
      if (accept) begin
        runSum   <= runSum + inPayload;
        // new result replaces one being taken in the same cycle
        outValid <= 1'b1;
      end else if (outTaken) begin
        outValid <= 1'b0;
      end
    end
  end

  // result offered right after the accepting edge
  assign outPayload = runSum;

endmodule

//--- rtl/coreTestHarness.sv
// core test harness sorting downstream words into drop, block and loopback paths
`timescale 1ns/1ns

module coreTestHarness import pcPkg::*; (
  input  logic     okClk,
  input  logic     arstN,
  pcChannel.sink   down,
  pcChannel.source up
);

  ////////////////////////////////////////////////////////////////////////////
  // code decode
  ////////////////////////////////////////////////////////////////////////////

  logic isNop;
  logic isBlock;
  logic downXfer;

  assign isNop    = (down.code == nopCode);
  assign isBlock  = (down.code == pcToBdCode);
  assign downXfer = down.valid & down.ack;

  // loopback register
  logic     lbValid;
  pcCode    lbCode;
  pcPayload lbPayload;
  logic     lbTaken;
  logic     lbReady;

  // block emulator hookup
  logic     bdInValid;
  logic     bdInAck;
  logic     bdOutValid;
  pcPayload bdOutPayload;
  logic     bdTaken;

  // return arbitration
  logic selLoop;
  logic freeSel;
  logic lastLoop;
  logic stall;
  logic stallLoop;

  // loopback slot frees up in the cycle it drains
  assign lbReady = ~lbValid | lbTaken;

  // NOPs always taken, others wait on their path
  always_comb begin
    if (isNop) begin
      down.ack = down.valid;
    end else if (isBlock) begin
      down.ack = down.valid & bdInAck;
    end else begin
      down.ack = down.valid & lbReady;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // loopback path
  ////////////////////////////////////////////////////////////////////////////

  // valid bit
  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      lbValid <= 1'b0;
    end else if (downXfer & ~isNop & ~isBlock) begin
      lbValid <= 1'b1;
    end else if (lbTaken) begin
      lbValid <= 1'b0;
    end
  end

  // word held unchanged for the return trip
  always_ff @(posedge okClk) begin
    if (downXfer & ~isNop & ~isBlock) begin
      lbCode    <= down.code;
      lbPayload <= down.payload;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // block path
  ////////////////////////////////////////////////////////////////////////////

  assign bdInValid = down.valid & isBlock;

  bdEmulator bdEmu (
    .okClk      (okClk),
    .arstN      (arstN),
    .inValid    (bdInValid),
    .inPayload  (down.payload),
    .inAck      (bdInAck),
    .outValid   (bdOutValid),
    .outPayload (bdOutPayload),
    .outTaken   (bdTaken)
  );

  ////////////////////////////////////////////////////////////////////////////
  // upstream round robin
  ////////////////////////////////////////////////////////////////////////////

  // with both full, the path not served last goes first
  assign freeSel = lbValid & (~bdOutValid | ~lastLoop);
  // an offered word keeps its path until acked
  assign selLoop = stall ? stallLoop : freeSel;

  assign up.valid   = lbValid | bdOutValid;
  assign up.code    = selLoop ? lbCode    : bdToPcCode;
  assign up.payload = selLoop ? lbPayload : bdOutPayload;

  assign lbTaken = up.valid & up.ack & selLoop;
  assign bdTaken = up.valid & up.ack & ~selLoop;

  always_ff @(posedge okClk or negedge arstN) begin
    if (!arstN) begin
      lastLoop  <= 1'b0;
      stall     <= 1'b0;
      stallLoop <= 1'b0;
    end else begin
      // remember a pending offer
      stall     <= up.valid & ~up.ack;
      stallLoop <= selLoop;
      if (up.valid & up.ack) begin
        lastLoop <= selLoop;
      end
    end
  end

endmodule

//--- rtl/pipeBridgeTop.sv
// host pipe bridge top with plain pipe-in and pipe-out ports
`timescale 1ns/1ns

module pipeBridgeTop import pcPkg::*; (
  input  logic  okClk,
  input  logic  arstN,
  // host pipe-in, no handshake beyond ready
  input  logic  pipeInWrite,
  input  pcWord pipeInData,
  output logic  pipeInReady,
  // host pipe-out, data answered in the read cycle
  input  logic  pipeOutRead,
  output pcWord pipeOutData,
  output logic  pipeOutReady
);

  ////////////////////////////////////////////////////////////////////////////
  // channels between the blocks
  ////////////////////////////////////////////////////////////////////////////

  // FIFO to harness
  pcChannel downstreamCh ();
  // harness to pipe-out selector
  pcChannel upstreamCh ();

  ////////////////////////////////////////////////////////////////////////////
  // downstream, FIFO sinking pipe-in
  ////////////////////////////////////////////////////////////////////////////

  // occupancy left open, ready is derived inside
  pipeInFifo fifoIn (
    .okClk     (okClk),
    .arstN     (arstN),
    .wrEn      (pipeInWrite),
    .wrData    (pipeInData),
    .ready     (pipeInReady),
    .usedCount (),
    .down      (downstreamCh.source)
  );

  ////////////////////////////////////////////////////////////////////////////
  // harness, sorts and returns words
  ////////////////////////////////////////////////////////////////////////////

  coreTestHarness coreHarness (
    .okClk (okClk),
    .arstN (arstN),
    .down  (downstreamCh.sink),
    .up    (upstreamCh.source)
  );

  ////////////////////////////////////////////////////////////////////////////
  // upstream, pending word or NOP
  ////////////////////////////////////////////////////////////////////////////

  upstreamMux upMux (
    .pipeOutRead (pipeOutRead),
    .pipeOutData (pipeOutData),
    .up          (upstreamCh.sink)
  );

  // something waiting for the host
  assign pipeOutReady = upstreamCh.valid;

endmodule

//--- verif/pipeBridgeTb.sv
// testbench for the host pipe bridge, checking loopback, block sums and NOP handling
`timescale 1ns/1ns

module pipeBridgeTb import pcPkg::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // DUT signals and reference state
  ////////////////////////////////////////////////////////////////////////////

  logic  okClk;
  logic  arstN;
  logic  pipeInWrite;
  pcWord pipeInData;
  logic  pipeInReady;
  logic  pipeOutRead;
  pcWord pipeOutData;
  logic  pipeOutReady;

  // idle answer from pipe-out
  localparam pcWord nopWord     = {nopCode, pcPayload'(0)};
  localparam int    waitLimit   = 5000;
  localparam int    blockMargin = 384;

  integer   seed;
  // expected loopback words, in write order
  pcWord    loopQ [$];
  // expected block results, one per block word
  pcPayload sumQ [$];
  pcPayload modelSum;
  logic     readEnable;
  logic [1:0] readPhase;
  int       idleReads;

  pipeBridgeTop dut_i (
    .okClk        (okClk),
    .arstN        (arstN),
    .pipeInWrite  (pipeInWrite),
    .pipeInData   (pipeInData),
    .pipeInReady  (pipeInReady),
    .pipeOutRead  (pipeOutRead),
    .pipeOutData  (pipeOutData),
    .pipeOutReady (pipeOutReady)
  );

  // 10 ns clock
  always #5 okClk = ~okClk;

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic failCheck(input string msg);
    $display("FAILED at %0t: %s", $time, msg);
    $display("Regression failed");
    $fatal(1, "stopping on first error");
  endtask

  task automatic abortTimeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", waitLimit, what);
    $display("Regression failed");
    $fatal(1, "stopping on timeout");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // host side stimulus
  ////////////////////////////////////////////////////////////////////////////

  // block code one time in four, NOP only when asked for
  task automatic pickWord(output pcCode code, output pcPayload payload, input bit allowNop);
    logic [31:0] r;
    r = $random(seed);
    payload = r[23:0];
    r = $random(seed);
    if (r[1:0] == 2'd0) begin
      code = pcToBdCode;
    end else if (allowNop && r[4:2] == 3'd0) begin
      code = nopCode;
    end else begin
      code = r[15:8];
      if (code == nopCode || code == bdToPcCode) begin
        code = 8'h11;
      end
    end
  endtask

  // drive one write and record what should come back
  task automatic driveWord(input pcCode code, input pcPayload payload);
    @(posedge okClk);
    pipeInWrite <= 1'b1;
    pipeInData  <= {code, payload};
    if (code == pcToBdCode) begin
      // running sum wraps at 24 bits
      modelSum = modelSum + payload;
      sumQ.push_back(modelSum);
    end else if (code != nopCode) begin
      loopQ.push_back({code, payload});
    end
  endtask

  // host honors pipeInReady before each write
  task automatic writeWord(input pcCode code, input pcPayload payload);
    int waitCycles;
    waitCycles = 0;
    @(negedge okClk);
    while (!pipeInReady) begin
      @(posedge okClk);
      pipeInWrite <= 1'b0;
      waitCycles++;
      if (waitCycles > waitLimit) begin
        abortTimeout("pipeInReady to rise");
      end
      @(negedge okClk);
    end
    driveWord(code, payload);
  endtask

  task automatic stopWrite();
    @(posedge okClk);
    pipeInWrite <= 1'b0;
  endtask

  task automatic setReads(input logic enable);
    @(negedge okClk);
    readEnable = enable;
  endtask

  // all queues empty and nothing left at pipe-out
  task automatic waitDrained();
    int waitCycles;
    waitCycles = 0;
    @(negedge okClk);
    while (loopQ.size() != 0 || sumQ.size() != 0 || pipeOutReady) begin
      waitCycles++;
      if (waitCycles > waitLimit) begin
        abortTimeout("all returned words to drain");
      end
      @(negedge okClk);
    end
  endtask

  task automatic waitIdleRead();
    int waitCycles;
    int start;
    waitCycles = 0;
    start = idleReads;
    @(negedge okClk);
    while (idleReads == start) begin
      waitCycles++;
      if (waitCycles > waitLimit) begin
        abortTimeout("an idle read of pipe-out");
      end
      @(negedge okClk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // pipe-out reader and checks
  ////////////////////////////////////////////////////////////////////////////

  // reads three cycles out of four while enabled
  always @(posedge okClk) begin
    readPhase   <= readPhase + 1'b1;
    pipeOutRead <= readEnable && (readPhase != 2'd3);
  end

  resetState: assert property (@(negedge okClk) !arstN |-> (pipeInReady && !pipeOutReady))
    else failCheck("ready flags wrong during reset");

  idleNop: assert property (@(negedge okClk)
    (pipeOutRead && !pipeOutReady) |-> (pipeOutData == nopWord))
    else failCheck($sformatf("idle read returned %h", pipeOutData));

  task automatic checkReturn(input pcWord word);
    pcCode    code;
    pcPayload payload;
    code    = word[wordWidth-1 -: codeWidth];
    payload = word[payloadWidth-1:0];
    noNopBack: assert (code != nopCode)
      else failCheck("a NOP word came back from the harness");
    if (code == bdToPcCode) begin
      sumPending: assert (sumQ.size() > 0)
        else failCheck("block result with no block word pending");
      sumMatch: assert (payload == sumQ[0])
        else failCheck($sformatf("block sum %h, expected %h", payload, sumQ[0]));
      void'(sumQ.pop_front());
    end else begin
      loopPending: assert (loopQ.size() > 0)
        else failCheck($sformatf("unexpected loopback word %h", word));
      loopMatch: assert (word == loopQ[0])
        else failCheck($sformatf("loopback word %h, expected %h", word, loopQ[0]));
      void'(loopQ.pop_front());
    end
  endtask

  // outputs stable half a cycle after the edge
  always @(negedge okClk) begin
    if (pipeOutRead) begin
      if (pipeOutReady) begin
        checkReturn(pipeOutData);
      end else begin
        idleReads++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    pcCode    code;
    pcPayload payload;
    int       writes;
    seed            = 40;
    okClk           = 1'b0;
    arstN           = 1'b1;
    pipeInWrite     = 1'b0;
    pipeInData      = '0;
    pipeOutRead     = 1'b0;
    readEnable      = 1'b1;
    readPhase       = '0;
    modelSum        = '0;
    idleReads       = 0;
    #2 arstN = 1'b0;
    repeat (8) @(posedge okClk);
    arstN <= 1'b1;
    @(negedge okClk);
    afterReset: assert (pipeInReady && !pipeOutReady && idleReads > 0)
      else failCheck("bad state right after reset");

    // mixed traffic with NOPs, host reading
    repeat (300) begin
      pickWord(code, payload, 1'b1);
      writeWord(code, payload);
    end
    stopWrite();
    waitDrained();
    waitIdleRead();

    // back-pressure, reads stopped until pipeInReady falls
    setReads(1'b0);
    writes = 0;
    @(negedge okClk);
    while (pipeInReady) begin
      pickWord(code, payload, 1'b0);
      driveWord(code, payload);
      writes++;
      if (writes > fifoDepth) begin
        failCheck("pipeInReady never fell with reads stopped");
      end
      @(negedge okClk);
    end
    stopWrite();
    backPressure: assert (loopQ.size() + sumQ.size() >= blockMargin)
      else failCheck($sformatf("pipeInReady fell with %0d words outstanding",
                               loopQ.size() + sumQ.size()));

    // resume reads, everything must come back once
    setReads(1'b1);
    waitDrained();
    waitIdleRead();

    $display("Regression passed");
    $finish;
  end

endmodule

//--- src.f
rtl/pcPkg.sv
rtl/pcChannel.sv
rtl/pipeInFifo.sv
rtl/upstreamMux.sv
rtl/bdEmulator.sv
rtl/coreTestHarness.sv
rtl/pipeBridgeTop.sv
verif/pipeBridgeTb.sv

//--- run.sh
#!/bin/sh
# build and run the host pipe bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module pipeBridgeTb -f src.f \
  --Mdir obj_dir -o simv

status=0
out=$(./obj_dir/simv) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx "Regression passed"; then
  exit 0
fi
echo "run.sh: simulation did not report success" >&2
exit 1
